// File: dv/sram_model.sv
`timescale 1ns/1ps

module sram_model import vga_pkg::*; #(
  parameter int ADDR_BITS = 20
) (
  input  sram_bus_t            bus,
  output logic [data_bits-1:0] rdata
);

  localparam int depth = 2 ** ADDR_BITS;

  logic [data_bits-1:0] mem [depth];

  // Power up as black.
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // Level write while we_n and ce_n are low.
  always @(bus) begin
    if (!bus.ce_n && !bus.we_n) begin
      mem[bus.addr[ADDR_BITS-1:0]] = bus.wdata;
    end
  end

  // Combinational read.
  always_comb begin
    if (!bus.ce_n && !bus.oe_n) begin
      rdata = mem[bus.addr[ADDR_BITS-1:0]];
    end else begin
      rdata = '0;
    end
  end

endmodule

// File: dv/vga_checker.sv
`timescale 1ns/1ps

module vga_checker import vga_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       bvalid,
  input logic       bready,
  input logic       awready,
  input axil_resp_e bresp,
  input logic       active,
  input logic [11:0] rgb
);

  // Response holds under back-pressure.
  assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("bvalid or bresp changed before bready");

  assert property (@(posedge clk) disable iff (rst)
    bvalid |-> !awready)
    else $error("awready high while a response is pending");

  // Black when the pixel two cycles back was in blanking.
  assert property (@(posedge clk) disable iff (rst)
    !$past(active, 2) |-> rgb == 12'h000)
    else $error("RGB not zero outside the active area");

endmodule

bind axil_frame_writer vga_checker axi_chk (
  .clk    (clk),
  .rst    (rst),
  .bvalid (bvalid),
  .bready (bready),
  .awready(awready),
  .bresp  (bresp),
  .active (1'b1),
  .rgb    (12'h000)
);

bind vga_sram_double_buf vga_checker video_chk (
  .clk    (clk),
  .rst    (rst),
  .bvalid (1'b0),
  .bready (1'b1),
  .awready(1'b0),
  .bresp  (OKAY),
  .active (active),
  .rgb    ({video.red, video.green, video.blue})
);

// File: dv/vga_tb.sv
`timescale 1ns/1ps

module vga_tb import vga_pkg::*; ();

  localparam int addr_bits = 6;
  localparam int h_act = 8;
  localparam int h_fp = 2;
  localparam int h_sync = 2;
  localparam int h_bp = 2;
  localparam int v_act = 4;
  localparam int v_fp = 1;
  localparam int v_sync = 1;
  localparam int v_bp = 1;
  localparam int h_total = h_act + h_fp + h_sync + h_bp;
  localparam int v_total = v_act + v_fp + v_sync + v_bp;
  localparam int frame_cycles = h_total * v_total;
  localparam int npix = h_act * v_act;
  localparam int clk_period = 4;
  localparam int watchdog_ns = 40 * frame_cycles * clk_period;

  logic       clk = 1'b0;
  logic       rst;
  logic       awvalid;
  logic       awready;
  axil_aw_t   aw;
  logic       wvalid;
  logic       wready;
  axil_w_t    w;
  logic       bvalid;
  logic       bready;
  axil_resp_e bresp;
  sram_bus_t  sram0_bus;
  sram_bus_t  sram1_bus;
  logic [data_bits-1:0] sram0_rdata;
  logic [data_bits-1:0] sram1_rdata;
  vga_out_t   video;

  int errors = 0;
  int checks = 0;
  logic [11:0] pat1 [npix];
  logic [11:0] pat2 [npix];
  logic [11:0] shown [npix];
  logic [11:0] zeros [npix];

  always #(clk_period / 2) clk = !clk;

  vga_sram_double_buf_top #(
    .ADDR_BITS(addr_bits),
    .H_ACTIVE(h_act), .H_FP(h_fp), .H_SYNC(h_sync), .H_BP(h_bp),
    .V_ACTIVE(v_act), .V_FP(v_fp), .V_SYNC(v_sync), .V_BP(v_bp)
  ) uut (
    .clk        (clk),
    .rst        (rst),
    .awvalid    (awvalid),
    .awready    (awready),
    .aw         (aw),
    .wvalid     (wvalid),
    .wready     (wready),
    .w          (w),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .sram0_bus  (sram0_bus),
    .sram0_rdata(sram0_rdata),
    .sram1_bus  (sram1_bus),
    .sram1_rdata(sram1_rdata),
    .video      (video)
  );

  sram_model #(.ADDR_BITS(addr_bits)) sram0 (.bus(sram0_bus), .rdata(sram0_rdata));
  sram_model #(.ADDR_BITS(addr_bits)) sram1 (.bus(sram1_bus), .rdata(sram1_rdata));

  task automatic compare_resp(input axil_resp_e got, input axil_resp_e exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %s expected %s", $time, msg, got.name(), exp.name());
    end
  endtask

  task automatic compare_video(input vga_out_t got, input vga_out_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string msg);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic wait_awready();
    int n;
    n = 0;
    @(negedge clk);
    while (!awready && n < 50) begin
      n++;
      @(negedge clk);
    end
    if (!awready) begin
      errors++;
      $display("Write address was never accepted at %0t", $time);
    end else begin
      compare_count(int'(wready), 1, "wready with awready");
    end
  endtask

  task automatic wait_bvalid();
    int n;
    n = 0;
    @(negedge clk);
    while (!bvalid && n < 50) begin
      n++;
      @(negedge clk);
    end
    if (!bvalid) begin
      errors++;
      $display("Write response never arrived at %0t", $time);
    end
  endtask

  task automatic axil_write(input logic [21:0] addr, input logic [15:0] data,
                            output axil_resp_e resp);
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    aw.addr <= addr;
    w.data <= data;
    wait_awready();
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    wait_bvalid();
    resp = bresp;
  endtask

  task automatic write_pattern(input logic [11:0] pat [npix]);
    axil_resp_e resp;
    for (int i = 0; i < npix; i++) begin
      axil_write({1'b0, 20'(i), 1'b0}, {4'h0, pat[i]}, resp);
      compare_resp(resp, OKAY, "pixel write");
    end
  endtask

  task automatic request_swap();
    axil_resp_e resp;
    axil_write(22'h200000, 16'h0001, resp);
    compare_resp(resp, OKAY, "swap write");
  endtask

  task automatic wait_vsync_rise();
    int n;
    logic prev;
    n = 0;
    @(negedge clk);
    prev = video.vsync;
    @(negedge clk);
    while (!(!prev && video.vsync) && n < 3 * frame_cycles) begin
      prev = video.vsync;
      n++;
      @(negedge clk);
    end
    if (n >= 3 * frame_cycles) begin
      errors++;
      $display("No vsync rising edge seen at %0t", $time);
    end
  endtask

  // Checks one whole frame, from the first cycle of vsync high.
  task automatic capture_frame(input logic [11:0] pix [npix], input string msg);
    vga_out_t exp;
    int v;
    int h;
    wait_vsync_rise();
    for (int n = 0; n < frame_cycles; n++) begin
      if (n > 0) @(negedge clk);
      v = (n / h_total + v_act + v_fp + v_sync) % v_total;
      h = n % h_total;
      exp.hsync = !(h >= h_act + h_fp && h < h_act + h_fp + h_sync);
      exp.vsync = !(v >= v_act + v_fp && v < v_act + v_fp + v_sync);
      if (v < v_act && h < h_act) begin
        {exp.red, exp.green, exp.blue} = pix[v * h_act + h];
      end else begin
        {exp.red, exp.green, exp.blue} = 12'h000;
      end
      compare_video(video, exp, msg);
    end
  endtask

  task automatic test_reset();
    compare_video(video, '{red: 4'h0, green: 4'h0, blue: 4'h0, hsync: 1'b1, vsync: 1'b1},
                  "video in reset");
    compare_count(int'(bvalid), 0, "bvalid in reset");
    compare_count(int'({awready, wready}), 0, "awready and wready in reset");
    compare_count(int'({sram0_bus.we_n, sram0_bus.oe_n, sram0_bus.ce_n}), 7, "sram0 strobes");
    compare_count(int'({sram1_bus.we_n, sram1_bus.oe_n, sram1_bus.ce_n}), 7, "sram1 strobes");
  endtask

  task automatic test_fill_and_swap();
    write_pattern(pat1);
    capture_frame(zeros, "frame before swap");
    request_swap();
    capture_frame(pat1, "frame after swap");
  endtask

  task automatic test_tear_free();
    fork
      write_pattern(pat2);
      capture_frame(pat1, "frame during update");
    join
    capture_frame(pat1, "frame after update");
    request_swap();
    capture_frame(pat2, "frame after second swap");
  endtask

  task automatic test_range_and_backpressure();
    axil_resp_e resp;
    // Word 72 aliases pixel 8 in the 6-bit SRAM.
    axil_write({1'b0, 20'd72, 1'b0}, 16'h0fff, resp);
    compare_resp(resp, SLVERR, "out of range write");
    capture_frame(pat2, "frame after bad write");
    request_swap();
    capture_frame(pat1, "back buffer after bad write");
    @(posedge clk);
    bready <= 1'b0;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    aw.addr <= {1'b0, 20'd3, 1'b0};
    w.data <= 16'h0123;
    wait_awready();
    @(posedge clk);
    aw.addr <= {1'b0, 20'd4, 1'b0};
    w.data <= 16'h0456;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      compare_count(int'(bvalid), 1, "bvalid under back-pressure");
      compare_count(int'(awready), 0, "awready under back-pressure");
      compare_count(int'(wready), 0, "wready under back-pressure");
    end
    compare_resp(bresp, OKAY, "held response");
    @(posedge clk);
    bready <= 1'b1;
    wait_awready();
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    wait_bvalid();
    compare_resp(bresp, OKAY, "write after back-pressure");
  endtask

  task automatic test_sync_shape();
    int hs_run;
    int hs_lines;
    int vs_run;
    int period;
    logic rose;
    wait_vsync_rise();
    hs_run = 0;
    hs_lines = 0;
    vs_run = 0;
    period = 0;
    rose = 1'b0;
    while (!rose && period < 2 * frame_cycles) begin
      @(negedge clk);
      period++;
      if (!video.hsync) begin
        hs_run++;
      end else if (hs_run != 0) begin
        compare_count(hs_run, h_sync, "hsync low cycles per line");
        hs_lines++;
        hs_run = 0;
      end
      if (!video.vsync) begin
        vs_run++;
      end else if (vs_run != 0) begin
        compare_count(vs_run, v_sync * h_total, "vsync low cycles per frame");
        rose = 1'b1;
      end
    end
    compare_count(hs_lines, v_total, "hsync pulses per frame");
    compare_count(period, frame_cycles, "vsync period");
  endtask

  // Watchdog.
  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish in time");
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(32'hfebdf66e));
    for (int i = 0; i < npix; i++) begin
      pat1[i] = 12'($urandom);
      pat2[i] = 12'($urandom);
      zeros[i] = 12'h000;
    end
    rst = 1'b1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
    aw = '0;
    w = '{data: 16'h0000, strb: 2'b11};
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    test_reset();
    test_fill_and_swap();
    test_tear_free();
    test_range_and_backpressure();
    test_sync_shape();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: hdl/axil_frame_writer.sv
`timescale 1ns/1ps

module axil_frame_writer import vga_pkg::*; #(
  parameter int ADDR_BITS = 20,
  parameter int H_ACTIVE = 640,
  parameter int V_ACTIVE = 480
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       awvalid,
  output logic       awready,
  input  axil_aw_t   aw,
  input  logic       wvalid,
  output logic       wready,
  input  axil_w_t    w,
  output logic       bvalid,
  input  logic       bready,
  output axil_resp_e bresp,
  output pix_write_t pix_wr,
  output logic       swap_req
);

  localparam int pix_count = H_ACTIVE * V_ACTIVE;

  logic                     accept;
  logic                     is_ctrl;
  logic                     in_range;
  logic [max_addr_bits-1:0] word_addr;
  pixel_word_u              wdata;

  // Take address and data together, never while a response waits.
  assign accept = awvalid && wvalid && !bvalid;
  assign awready = accept;
  assign wready = accept;

  assign is_ctrl = aw.addr[max_addr_bits+1];
  assign word_addr = aw.addr[max_addr_bits:1];
  assign in_range = (word_addr < max_addr_bits'(pix_count));
  assign wdata = w.data;

  assign pix_wr.valid = accept && !is_ctrl && in_range;
  assign pix_wr.addr = max_addr_bits'(word_addr[ADDR_BITS-1:0]);
  assign pix_wr.pix = wdata.pix;

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
      swap_req <= 1'b0;
    end else begin
      swap_req <= accept && is_ctrl && wdata.ctrl.swap;
      if (accept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      bresp <= (is_ctrl || in_range) ? OKAY : SLVERR;
    end
  end

endmodule

// File: hdl/sram_port.sv
`timescale 1ns/1ps

module sram_port import vga_pkg::*; #(
  parameter int ADDR_BITS = 20
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 scan_en,
  input  logic [ADDR_BITS-1:0] scan_addr,
  input  pix_write_t           wr,
  output sram_bus_t            bus,
  input  logic [data_bits-1:0] rdata,
  output logic [data_bits-1:0] rdata_q
);

  // Address and data.
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      bus.addr <= max_addr_bits'(wr.addr[ADDR_BITS-1:0]);
      bus.wdata <= wr.pix;
    end else begin
      bus.addr <= max_addr_bits'(scan_addr);
      bus.wdata <= '0;
    end
  end

  // Strobes, idle high.
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.we_n <= 1'b1;
      bus.oe_n <= 1'b1;
      bus.ce_n <= 1'b1;
    end else if (wr.valid) begin
      bus.we_n <= 1'b0;
      bus.oe_n <= 1'b1;
      bus.ce_n <= 1'b0;
    end else if (scan_en) begin
      bus.we_n <= 1'b1;
      bus.oe_n <= 1'b0;
      bus.ce_n <= 1'b0;
    end else begin
      bus.we_n <= 1'b1;
      bus.oe_n <= 1'b1;
      bus.ce_n <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= rdata;
  end

endmodule

// File: hdl/vga_pkg.sv
package vga_pkg;

  localparam int data_bits = 16;
  localparam int max_addr_bits = 20;

  typedef struct packed {
    logic [3:0] unused;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb444_t;

  typedef struct packed {
    logic [14:0] reserved;
    logic        swap;
  } ctrl_word_t;

  // Same write word, read as a pixel or as a control word.
  typedef union packed {
    rgb444_t    pix;
    ctrl_word_t ctrl;
  } pixel_word_u;

  typedef struct packed {
    logic [max_addr_bits-1:0] addr;
    logic [data_bits-1:0]     wdata;
    logic                     we_n;
    logic                     oe_n;
    logic                     ce_n;
  } sram_bus_t;

  // Bit 0 is the byte bit, top bit selects the control register.
  typedef struct packed {
    logic [max_addr_bits+1:0] addr;
    logic [2:0]               prot;
  } axil_aw_t;

  typedef struct packed {
    logic [data_bits-1:0] data;
    logic [1:0]           strb;
  } axil_w_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hsync;
    logic       vsync;
  } vga_out_t;

  typedef struct packed {
    logic                     valid;
    logic [max_addr_bits-1:0] addr;
    rgb444_t                  pix;
  } pix_write_t;

endpackage

// File: hdl/vga_sram_double_buf.sv
`timescale 1ns/1ps

module vga_sram_double_buf import vga_pkg::*; #(
  parameter int ADDR_BITS = 20,
  parameter int H_ACTIVE = 640,
  parameter int V_ACTIVE = 480
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 active,
  input  logic                 hsync_n,
  input  logic                 vsync_n,
  input  logic                 frame_end,
  input  pix_write_t           pix_wr,
  input  logic                 swap_req,
  output logic                 scan0_en,
  output logic [ADDR_BITS-1:0] scan0_addr,
  output logic                 scan1_en,
  output logic [ADDR_BITS-1:0] scan1_addr,
  output pix_write_t           wr0,
  output pix_write_t           wr1,
  input  logic [data_bits-1:0] rdata0_q,
  input  logic [data_bits-1:0] rdata1_q,
  output vga_out_t             video
);

  localparam int pix_count = H_ACTIVE * V_ACTIVE;

  typedef struct packed {
    logic active;
    logic hsync_n;
    logic vsync_n;
    logic sel;
  } scan_stage_t;

  logic [ADDR_BITS-1:0] scan_cnt;
  logic                 front_sel;
  logic                 swap_pending;
  scan_stage_t          stage1;
  scan_stage_t          stage2;
  rgb444_t              pix;

  // Front buffer is read, back buffer is written.
  assign scan0_en = active && !front_sel;
  assign scan1_en = active && front_sel;
  assign scan0_addr = scan_cnt;
  assign scan1_addr = scan_cnt;

  always_comb begin
    wr0 = pix_wr;
    wr1 = pix_wr;
    wr0.valid = pix_wr.valid && front_sel;
    wr1.valid = pix_wr.valid && !front_sel;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      scan_cnt <= '0;
      front_sel <= 1'b0;
      swap_pending <= 1'b0;
    end else begin
      if (frame_end) begin
        scan_cnt <= '0;
      end else if (active) begin
        scan_cnt <= (scan_cnt == ADDR_BITS'(pix_count - 1)) ? '0 : scan_cnt + 1'b1;
      end
      // Swap only at the frame boundary.
      if (frame_end && swap_pending) begin
        front_sel <= !front_sel;
        swap_pending <= swap_req;
      end else if (swap_req) begin
        swap_pending <= 1'b1;
      end
    end
  end

  // Two stages to match address register and read capture.
  always_ff @(posedge clk) begin
    if (rst) begin
      stage1 <= '{active: 1'b0, hsync_n: 1'b1, vsync_n: 1'b1, sel: 1'b0};
      stage2 <= '{active: 1'b0, hsync_n: 1'b1, vsync_n: 1'b1, sel: 1'b0};
    end else begin
      stage1 <= '{active: active, hsync_n: hsync_n, vsync_n: vsync_n, sel: front_sel};
      stage2 <= stage1;
    end
  end

  assign pix = rgb444_t'(stage2.sel ? rdata1_q : rdata0_q);

  // Black outside the active area.
  assign video.red = stage2.active ? pix.red : 4'h0;
  assign video.green = stage2.active ? pix.green : 4'h0;
  assign video.blue = stage2.active ? pix.blue : 4'h0;
  assign video.hsync = stage2.hsync_n;
  assign video.vsync = stage2.vsync_n;

endmodule

// File: hdl/vga_sram_double_buf_top.sv
`timescale 1ns/1ps

module vga_sram_double_buf_top import vga_pkg::*; #(
  parameter int ADDR_BITS = 20,
  parameter int H_ACTIVE = 640,
  parameter int H_FP = 16,
  parameter int H_SYNC = 96,
  parameter int H_BP = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP = 10,
  parameter int V_SYNC = 2,
  parameter int V_BP = 33
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 awvalid,
  output logic                 awready,
  input  axil_aw_t             aw,
  input  logic                 wvalid,
  output logic                 wready,
  input  axil_w_t              w,
  output logic                 bvalid,
  input  logic                 bready,
  output axil_resp_e           bresp,
  output sram_bus_t            sram0_bus,
  input  logic [data_bits-1:0] sram0_rdata,
  output sram_bus_t            sram1_bus,
  input  logic [data_bits-1:0] sram1_rdata,
  output vga_out_t             video
);

  logic                 active;
  logic                 hsync_n;
  logic                 vsync_n;
  logic                 frame_end;
  logic                 swap_req;
  pix_write_t           pix_wr;
  pix_write_t           wr0;
  pix_write_t           wr1;
  logic                 scan0_en;
  logic                 scan1_en;
  logic [ADDR_BITS-1:0] scan0_addr;
  logic [ADDR_BITS-1:0] scan1_addr;
  logic [data_bits-1:0] rdata0_q;
  logic [data_bits-1:0] rdata1_q;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) timing_inst (
    .clk      (clk),
    .rst      (rst),
    .active   (active),
    .hsync_n  (hsync_n),
    .vsync_n  (vsync_n),
    .frame_end(frame_end)
  );

  axil_frame_writer #(
    .ADDR_BITS(ADDR_BITS), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
  ) writer_inst (
    .clk     (clk),
    .rst     (rst),
    .awvalid (awvalid),
    .awready (awready),
    .aw      (aw),
    .wvalid  (wvalid),
    .wready  (wready),
    .w       (w),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .pix_wr  (pix_wr),
    .swap_req(swap_req)
  );

  vga_sram_double_buf #(
    .ADDR_BITS(ADDR_BITS), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
  ) core_inst (
    .clk       (clk),
    .rst       (rst),
    .active    (active),
    .hsync_n   (hsync_n),
    .vsync_n   (vsync_n),
    .frame_end (frame_end),
    .pix_wr    (pix_wr),
    .swap_req  (swap_req),
    .scan0_en  (scan0_en),
    .scan0_addr(scan0_addr),
    .scan1_en  (scan1_en),
    .scan1_addr(scan1_addr),
    .wr0       (wr0),
    .wr1       (wr1),
    .rdata0_q  (rdata0_q),
    .rdata1_q  (rdata1_q),
    .video     (video)
  );

  sram_port #(.ADDR_BITS(ADDR_BITS)) sram0_inst (
    .clk      (clk),
    .rst      (rst),
    .scan_en  (scan0_en),
    .scan_addr(scan0_addr),
    .wr       (wr0),
    .bus      (sram0_bus),
    .rdata    (sram0_rdata),
    .rdata_q  (rdata0_q)
  );

  sram_port #(.ADDR_BITS(ADDR_BITS)) sram1_inst (
    .clk      (clk),
    .rst      (rst),
    .scan_en  (scan1_en),
    .scan_addr(scan1_addr),
    .wr       (wr1),
    .bus      (sram1_bus),
    .rdata    (sram1_rdata),
    .rdata_q  (rdata1_q)
  );

endmodule

// File: hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FP = 16,
  parameter int H_SYNC = 96,
  parameter int H_BP = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP = 10,
  parameter int V_SYNC = 2,
  parameter int V_BP = 33
) (
  input  logic clk,
  input  logic rst,
  output logic active,
  output logic hsync_n,
  output logic vsync_n,
  output logic frame_end
);

  localparam int h_total = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int v_total = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int h_bits = $clog2(h_total);
  localparam int v_bits = $clog2(v_total);
  localparam int hs_start = H_ACTIVE + H_FP;
  localparam int vs_start = V_ACTIVE + V_FP;

  logic [h_bits-1:0] h_cnt;
  logic [v_bits-1:0] v_cnt;
  logic [h_bits-1:0] h_next;
  logic [v_bits-1:0] v_next;
  logic              line_end;

  assign line_end = (h_cnt == h_bits'(h_total - 1));
  assign frame_end = line_end && (v_cnt == v_bits'(v_total - 1));
  assign active = (h_cnt < h_bits'(H_ACTIVE)) && (v_cnt < v_bits'(V_ACTIVE));

  assign h_next = line_end ? '0 : h_cnt + 1'b1;
  assign v_next = frame_end ? '0 : (line_end ? v_cnt + 1'b1 : v_cnt);

  // Syncs come from the next count so they line up with the counters.
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
    end else begin
      h_cnt <= h_next;
      v_cnt <= v_next;
      hsync_n <= !((h_next >= h_bits'(hs_start)) && (h_next < h_bits'(hs_start + H_SYNC)));
      vsync_n <= !((v_next >= v_bits'(vs_start)) && (v_next < v_bits'(vs_start + V_SYNC)));
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the VGA double-buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module vga_tb -Mdir obj_dir -o vga_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vga_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0

// File: verilog.f
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/sram_port.sv
hdl/axil_frame_writer.sv
hdl/vga_sram_double_buf.sv
hdl/vga_sram_double_buf_top.sv
dv/sram_model.sv
dv/vga_checker.sv
dv/vga_tb.sv
